// File: vread_pkg.sv
package vread_pkg;

   // local buffer, top bit selects the ping-pong bank
   localparam int BUF_ADDR_W = 10;
   localparam int PERIOD_W   = 8;

   // external databus
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int LEN_W      = 8;

   // word count needs one bit more than amount_minus_one
   localparam int COUNT_W        = BUF_ADDR_W + 1;
   localparam int BYTES_PER_WORD = AXI_DATA_W / 8;

   typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   // one loop level of the address generator
   typedef struct packed {
      buf_addr_t           start;
      logic [PERIOD_W-1:0] per;
      logic [PERIOD_W-1:0] duty;
      buf_addr_t           incr;
      buf_addr_t           iter;
      buf_addr_t           shift;
   } gen_cfg_t;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] ext_addr;
      buf_addr_t             amount_minus_one;
      logic [LEN_W-1:0]      burst_len;
   } read_cfg_t;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } db_req_t;

   typedef struct packed {
      buf_addr_t addr;
      axi_data_t data;
   } buf_wr_t;

endpackage

// File: vread_cfg_decode.sv
module vread_cfg_decode (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   input  logic                             done_i,
   input  logic                             ping_pong_i,
   input  logic                             read_enabled_i,
   input  vread_pkg::read_cfg_t             read_cfg_i,
   input  vread_pkg::gen_cfg_t              read_gen_i,
   input  vread_pkg::gen_cfg_t              out_gen_i,
   output vread_pkg::read_cfg_t             read_cfg_o,
   output vread_pkg::gen_cfg_t              read_gen_o,
   output vread_pkg::gen_cfg_t              out_gen_o,
   output logic [vread_pkg::COUNT_W-1:0]    count_o,
   output logic                             bank_o,
   output logic                             ping_pong_o,
   output logic                             fetch_start_o,
   output logic                             out_start_o
);

   import vread_pkg::*;

   logic accept;

   // a run only counts while the unit is idle
   assign accept = run_i && done_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_o        <= 1'b0;
         ping_pong_o   <= 1'b0;
         fetch_start_o <= 1'b0;
         out_start_o   <= 1'b0;
      end else begin
         fetch_start_o <= accept && read_enabled_i;
         out_start_o   <= accept;
         if (accept) begin
            // bank flips per run, parked at 0 without ping-pong
            bank_o      <= ping_pong_i ? !bank_o : 1'b0;
            ping_pong_o <= ping_pong_i;
         end
      end
   end

   // configuration held for the whole run
   always_ff @(posedge clk) begin
      if (accept) begin
         read_cfg_o <= read_cfg_i;
         read_gen_o <= read_gen_i;
         out_gen_o  <= out_gen_i;
         count_o    <= COUNT_W'(read_cfg_i.amount_minus_one) + 1'b1;
      end
   end

endmodule

// File: vread_addr_gen.sv
module vread_addr_gen (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                start_i,
   input  vread_pkg::gen_cfg_t                 cfg_i,
   input  logic                                ready_i,
   output logic                                valid_o,
   output logic [vread_pkg::BUF_ADDR_W-1:0]    addr_o,
   output logic                                done_o
);

   import vread_pkg::*;

   logic                  active;
   logic [PERIOD_W-1:0]   pos;
   logic [BUF_ADDR_W-1:0] iter_cnt;
   logic [BUF_ADDR_W-1:0] incr_step;
   logic                  step;
   logic                  period_end;
   logic                  last_period;

   // first duty positions of each period are valid
   assign valid_o = active && (pos < cfg_i.duty);

   // gap positions pass on their own, valid ones wait for ready
   assign step = active && (!valid_o || ready_i);

   assign period_end  = (pos == cfg_i.per - 1'b1);
   assign last_period = (iter_cnt == cfg_i.iter - 1'b1);
   assign incr_step   = valid_o ? cfg_i.incr : '0;

   // busy already in the strobe cycle
   assign done_o = !active && !start_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active   <= 1'b0;
         pos      <= '0;
         iter_cnt <= '0;
         addr_o   <= '0;
      end else if (start_i) begin
         // a zero period or zero iterations gives an empty walk
         active   <= (cfg_i.per != '0) && (cfg_i.iter != '0);
         pos      <= '0;
         iter_cnt <= '0;
         addr_o   <= cfg_i.start;
      end else if (step) begin
         if (period_end) begin
            pos    <= '0;
            addr_o <= addr_o + incr_step + cfg_i.shift;
            if (last_period) begin
               active <= 1'b0;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            pos    <= pos + 1'b1;
            addr_o <= addr_o + incr_step;
         end
      end
   end

endmodule

// File: vread_burst_fetch.sv
module vread_burst_fetch (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             start_i,
   input  vread_pkg::read_cfg_t             cfg_i,
   input  logic [vread_pkg::COUNT_W-1:0]    count_i,
   input  logic                             db_ready_i,
   input  logic                             db_last_i,
   output logic                             db_valid_o,
   output vread_pkg::db_req_t               db_req_o,
   output logic                             beat_o,
   output logic                             done_o
);

   import vread_pkg::*;

   // words still owed by the memory
   logic [COUNT_W-1:0] remaining;
   logic [COUNT_W-1:0] left;
   logic               burst_end;

   function automatic logic [LEN_W-1:0] burst_size(input logic [COUNT_W-1:0] words,
                                                   input logic [LEN_W-1:0]   max_len);
      if (words < COUNT_W'(max_len)) begin
         return LEN_W'(words);
      end else begin
         return max_len;
      end
   endfunction

   assign beat_o    = db_valid_o && db_ready_i;
   assign left      = remaining - 1'b1;
   assign burst_end = beat_o && db_last_i;
   assign done_o    = !db_valid_o && !start_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         db_valid_o <= 1'b0;
         remaining  <= '0;
      end else if (start_i) begin
         db_valid_o <= 1'b1;
         remaining  <= count_i;
      end else if (beat_o) begin
         remaining <= left;
         if (burst_end && (left == '0)) begin
            db_valid_o <= 1'b0;
         end
      end
   end

   // next burst issued on the last beat, so the request never drops between bursts
   always_ff @(posedge clk) begin
      if (start_i) begin
         db_req_o.addr <= cfg_i.ext_addr;
         db_req_o.len  <= burst_size(count_i, cfg_i.burst_len);
      end else if (burst_end && (left != '0)) begin
         db_req_o.addr <= db_req_o.addr + AXI_ADDR_W'(db_req_o.len) * BYTES_PER_WORD;
         db_req_o.len  <= burst_size(left, cfg_i.burst_len);
      end
   end

endmodule

// File: vread_join.sv
module vread_join #(
   parameter type FIRST_T  = logic,
   parameter type SECOND_T = logic
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    first_valid_i,
   input  FIRST_T  first_i,
   output logic    first_ready_o,
   input  logic    second_valid_i,
   input  SECOND_T second_i,
   output logic    second_ready_o,
   output logic    result_valid_o,
   output FIRST_T  result_first_o,
   output SECOND_T result_second_o
);

   logic fire;

   // the result is consumed every cycle, so the register is always free
   assign fire           = first_valid_i && second_valid_i;
   assign first_ready_o  = second_valid_i;
   assign second_ready_o = first_valid_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_valid_o <= 1'b0;
      end else begin
         result_valid_o <= fire;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         result_first_o  <= first_i;
         result_second_o <= second_i;
      end
   end

endmodule

// File: vread_output_stream.sv
module vread_output_stream #(
   parameter int DATA_W = 8
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                start_i,
   input  vread_pkg::gen_cfg_t                 cfg_i,
   input  logic                                bank_i,
   input  logic                                ping_pong_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0]    buf_rd_data_i,
   output logic                                buf_rd_o,
   output logic [vread_pkg::BUF_ADDR_W-1:0]    buf_rd_addr_o,
   output logic                                out_valid_o,
   output logic [DATA_W-1:0]                   out_data_o,
   output logic                                done_o
);

   import vread_pkg::*;

   // output words per buffer word
   localparam int RATIO = AXI_DATA_W / DATA_W;
   localparam int SHIFT = $clog2(RATIO);
   localparam int SEL_W = (SHIFT > 0) ? SHIFT : 1;

   logic [BUF_ADDR_W-1:0] sym_addr;
   logic [BUF_ADDR_W-2:0] bank_word;
   logic [SEL_W-1:0]      sel_q;
   logic                  gen_done;

   // never stalled
   vread_addr_gen i_out_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (start_i),
      .cfg_i   (cfg_i),
      .ready_i (1'b1),
      .valid_o (buf_rd_o),
      .addr_o  (sym_addr),
      .done_o  (gen_done)
   );

   // symbol address to buffer word, bank bit kept on top
   assign bank_word = sym_addr[BUF_ADDR_W-2:0] >> SHIFT;

   always_comb begin
      if (ping_pong_i) begin
         buf_rd_addr_o = {bank_i, bank_word};
      end else begin
         buf_rd_addr_o = sym_addr >> SHIFT;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= buf_rd_o;
      end
   end

   // select lines up with the one-cycle buffer read
   always_ff @(posedge clk) begin
      if (buf_rd_o) begin
         sel_q <= sym_addr[SEL_W-1:0] & SEL_W'(RATIO - 1);
      end
   end

   // lowest slice first
   assign out_data_o = buf_rd_data_i[sel_q*DATA_W +: DATA_W];

   // last word must leave before done
   assign done_o = gen_done && !out_valid_o;

endmodule

// File: vread_top.sv
module vread_top #(
   parameter int DATA_W = 8
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run_i,
   output logic                                done_o,
   input  logic                                ping_pong_i,
   input  logic                                read_enabled_i,
   input  vread_pkg::read_cfg_t                read_cfg_i,
   input  vread_pkg::gen_cfg_t                 read_gen_i,
   input  vread_pkg::gen_cfg_t                 out_gen_i,
   output logic                                db_valid_o,
   output vread_pkg::db_req_t                  db_req_o,
   input  logic                                db_ready_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0]    db_rdata_i,
   input  logic                                db_last_i,
   output logic                                buf_we_o,
   output vread_pkg::buf_wr_t                  buf_wr_o,
   output logic                                buf_rd_o,
   output logic [vread_pkg::BUF_ADDR_W-1:0]    buf_rd_addr_o,
   input  logic [vread_pkg::AXI_DATA_W-1:0]    buf_rd_data_i,
   output logic                                out_valid_o,
   output logic [DATA_W-1:0]                   out_data_o
);

   import vread_pkg::*;

   read_cfg_t          read_cfg;
   gen_cfg_t           read_gen;
   gen_cfg_t           out_gen;
   logic [COUNT_W-1:0] count;
   logic               bank;
   logic               ping_pong;
   logic               fetch_start;
   logic               out_start;
   logic               fetch_valid;
   logic               fetch_ready;
   buf_addr_t          fetch_raw;
   buf_addr_t          fetch_addr;
   logic               beat;
   logic               fetch_done;
   logic               out_done;
   buf_addr_t          wr_addr;
   axi_data_t          wr_data;

   vread_cfg_decode i_decode (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .done_i         (done_o),
      .ping_pong_i    (ping_pong_i),
      .read_enabled_i (read_enabled_i),
      .read_cfg_i     (read_cfg_i),
      .read_gen_i     (read_gen_i),
      .out_gen_i      (out_gen_i),
      .read_cfg_o     (read_cfg),
      .read_gen_o     (read_gen),
      .out_gen_o      (out_gen),
      .count_o        (count),
      .bank_o         (bank),
      .ping_pong_o    (ping_pong),
      .fetch_start_o  (fetch_start),
      .out_start_o    (out_start)
   );

   // beats only land on valid positions, so the fetch walk normally has duty equal to per
   vread_addr_gen i_fetch_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (fetch_start),
      .cfg_i   (read_gen),
      .ready_i (fetch_ready),
      .valid_o (fetch_valid),
      .addr_o  (fetch_raw),
      .done_o  ()
   );

   // writes go to the bank the output is not reading
   assign fetch_addr = ping_pong ? {~bank, fetch_raw[BUF_ADDR_W-2:0]} : fetch_raw;

   vread_burst_fetch i_fetch (
      .clk        (clk),
      .rst        (rst),
      .start_i    (fetch_start),
      .cfg_i      (read_cfg),
      .count_i    (count),
      .db_ready_i (db_ready_i),
      .db_last_i  (db_last_i),
      .db_valid_o (db_valid_o),
      .db_req_o   (db_req_o),
      .beat_o     (beat),
      .done_o     (fetch_done)
   );

   // memory side cannot be held back
   vread_join #(
      .FIRST_T  (buf_addr_t),
      .SECOND_T (axi_data_t)
   ) i_join (
      .clk             (clk),
      .rst             (rst),
      .first_valid_i   (fetch_valid),
      .first_i         (fetch_addr),
      .first_ready_o   (fetch_ready),
      .second_valid_i  (beat),
      .second_i        (db_rdata_i),
      .second_ready_o  (),
      .result_valid_o  (buf_we_o),
      .result_first_o  (wr_addr),
      .result_second_o (wr_data)
   );

   assign buf_wr_o.addr = wr_addr;
   assign buf_wr_o.data = wr_data;

   vread_output_stream #(
      .DATA_W (DATA_W)
   ) i_out (
      .clk           (clk),
      .rst           (rst),
      .start_i       (out_start),
      .cfg_i         (out_gen),
      .bank_i        (bank),
      .ping_pong_i   (ping_pong),
      .buf_rd_data_i (buf_rd_data_i),
      .buf_rd_o      (buf_rd_o),
      .buf_rd_addr_o (buf_rd_addr_o),
      .out_valid_o   (out_valid_o),
      .out_data_o    (out_data_o),
      .done_o        (out_done)
   );

   // fetch side is finished once its last write has left the join
   assign done_o = fetch_done && !buf_we_o && out_done;

endmodule

// File: vread_chk.sv
module vread_chk (
   input logic                 clk,
   input logic                 rst,
   input logic                 run_i,
   input logic                 done_i,
   input logic                 db_valid_i,
   input logic                 db_ready_i,
   input logic                 db_last_i,
   input vread_pkg::db_req_t   db_req_i,
   input logic                 buf_rd_i,
   input logic                 out_valid_i,
   input logic                 bank_i,
   input logic                 out_start_i,
   input vread_pkg::gen_cfg_t  out_gen_i,
   input vread_pkg::read_cfg_t read_cfg_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // request held from issue until its last beat
   assert property (@(posedge clk) disable iff (rst)
      db_valid_i && !(db_ready_i && db_last_i) |=> db_valid_i && $stable(db_req_i))
      else $error("databus request changed before its last beat");

   // one-cycle buffer read
   assert property (@(posedge clk) disable iff (rst) out_valid_i == $past(buf_rd_i))
      else $error("out_valid_o does not follow buf_rd_o by one cycle");

   // a busy unit ignores run
   assert property (@(posedge clk) disable iff (rst)
      run_i && !done_i |=> !out_start_i && $stable(bank_i) && $stable(out_gen_i)
         && $stable(read_cfg_i))
      else $error("run while busy changed the unit state");

endmodule

bind vread_top vread_chk i_chk (
   .clk         (clk),
   .rst         (rst),
   .run_i       (run_i),
   .done_i      (done_o),
   .db_valid_i  (db_valid_o),
   .db_ready_i  (db_ready_i),
   .db_last_i   (db_last_i),
   .db_req_i    (db_req_o),
   .buf_rd_i    (buf_rd_o),
   .out_valid_i (out_valid_o),
   .bank_i      (bank),
   .out_start_i (out_start),
   .out_gen_i   (out_gen),
   .read_cfg_i  (read_cfg)
);

// File: tb_vread.sv
module tb_vread;
   timeunit 1ns;
   timeprecision 1ps;

   import vread_pkg::*;

   localparam int DATA_W       = 8;
   localparam int RATIO        = AXI_DATA_W / DATA_W;
   localparam int SYM_SHIFT    = $clog2(RATIO);
   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_ROWS     = 5;
   localparam int EXT_W        = 8;
   localparam int EXT_WORDS    = 1 << EXT_W;
   localparam int BUF_WORDS    = 1 << BUF_ADDR_W;
   localparam logic [31:0] SEED = 32'h702b_69a3;

   typedef struct packed {
      read_cfg_t   rcfg;
      gen_cfg_t    fgen;
      gen_cfg_t    ogen;
      logic        pp;
      logic        ren;
      int unsigned exp_words;
      int unsigned exp_outs;
   } row_t;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  run_i;
   logic                  done_o;
   logic                  ping_pong_i;
   logic                  read_enabled_i;
   read_cfg_t             read_cfg_i;
   gen_cfg_t              read_gen_i;
   gen_cfg_t              out_gen_i;
   logic                  db_valid_o;
   db_req_t               db_req_o;
   logic                  db_ready_i;
   axi_data_t             db_rdata_i;
   logic                  db_last_i;
   logic                  buf_we_o;
   buf_wr_t               buf_wr_o;
   logic                  buf_rd_o;
   buf_addr_t             buf_rd_addr_o;
   axi_data_t             buf_rd_data_i;
   logic                  out_valid_o;
   logic [DATA_W-1:0]     out_data_o;

   // reference model state
   logic [31:0]           lfsr;
   axi_data_t             ext_mem [EXT_WORDS];
   axi_data_t             buf_mem [BUF_WORDS];
   axi_data_t             pred_buf [BUF_WORDS];
   buf_wr_t               wr_q [$];
   logic [DATA_W-1:0]     out_q [$];
   buf_addr_t             walk_q [$];
   row_t                  rows [NUM_ROWS];
   logic                  model_bank;
   logic                  cur_ren;
   logic [AXI_ADDR_W-1:0] burst_addr;
   int                    burst_left;
   int                    burst_max;
   logic [LEN_W-1:0]      beat_cnt;
   int                    writes_seen;
   int                    outs_seen;

   vread_top #(.DATA_W(DATA_W)) i_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1, shifting right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end else begin
         return s >> 1;
      end
   endfunction

   function automatic logic random_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr_next(lfsr);
      return b;
   endfunction

   function automatic axi_data_t buf_fill(input buf_addr_t a);
      return {a, ~a, 12'h5c3};
   endfunction

   function automatic gen_cfg_t make_gen(input buf_addr_t start, input logic [7:0] per,
                                         input logic [7:0] duty, input buf_addr_t incr,
                                         input buf_addr_t iter, input buf_addr_t shift);
      gen_cfg_t g;
      g.start = start;
      g.per   = per;
      g.duty  = duty;
      g.incr  = incr;
      g.iter  = iter;
      g.shift = shift;
      return g;
   endfunction

   function automatic read_cfg_t make_read(input logic [31:0] ext_addr,
                                           input buf_addr_t amount_m1, input logic [7:0] len);
      read_cfg_t c;
      c.ext_addr         = ext_addr;
      c.amount_minus_one = amount_m1;
      c.burst_len        = len;
      return c;
   endfunction

   task automatic stop_on_error();
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic load_table();
      // bank 1 fill read out while bank 0 takes 16 words in bursts of 5
      rows[0] = '{rcfg: make_read(32'h40, 10'd15, 8'd5),
                  fgen: make_gen(10'h000, 8'd8, 8'd8, 10'd1, 10'd2, 10'd0),
                  ogen: make_gen(10'h000, 8'd6, 8'd4, 10'd1, 10'd3, 10'd8),
                  pp: 1'b1, ren: 1'b1, exp_words: 16, exp_outs: 12};
      // reads back the words of row 0
      rows[1] = '{rcfg: make_read(32'h100, 10'd11, 8'd4),
                  fgen: make_gen(10'h020, 8'd4, 8'd4, 10'd1, 10'd3, 10'd4),
                  ogen: make_gen(10'h002, 8'd3, 8'd3, 10'd5, 10'd4, 10'd1),
                  pp: 1'b1, ren: 1'b1, exp_words: 12, exp_outs: 12};
      // no ping-pong, single burst shorter than burst_len
      rows[2] = '{rcfg: make_read(32'h200, 10'd9, 8'd16),
                  fgen: make_gen(10'h080, 8'd10, 8'd10, 10'd1, 10'd1, 10'd0),
                  ogen: make_gen(10'h010, 8'd2, 8'd1, 10'd3, 10'd8, 10'd2),
                  pp: 1'b0, ren: 1'b1, exp_words: 10, exp_outs: 8};
      // fetch off, output only
      rows[3] = '{rcfg: make_read(32'h0, 10'd3, 8'd4),
                  fgen: make_gen(10'h000, 8'd1, 8'd1, 10'd1, 10'd1, 10'd0),
                  ogen: make_gen(10'h200, 8'd5, 8'd5, 10'd3, 10'd2, 10'd7),
                  pp: 1'b0, ren: 1'b0, exp_words: 0, exp_outs: 10};
      // reads bank 1 as written by row 1
      rows[4] = '{rcfg: make_read(32'h300, 10'd20, 8'd8),
                  fgen: make_gen(10'h040, 8'd7, 8'd7, 10'd1, 10'd3, 10'd0),
                  ogen: make_gen(10'h080, 8'd4, 8'd4, 10'd1, 10'd3, 10'd28),
                  pp: 1'b1, ren: 1'b1, exp_words: 21, exp_outs: 12};
   endtask

   // one loop level, incr after each valid position, shift after each period
   task automatic walk_generator(input gen_cfg_t g);
      buf_addr_t a;
      int it;
      int p;
      walk_q.delete();
      a = g.start;
      for (it = 0; it < int'(g.iter); it++) begin
         for (p = 0; p < int'(g.per); p++) begin
            if (p < int'(g.duty)) begin
               walk_q.push_back(a);
               a = a + g.incr;
            end
         end
         a = a + g.shift;
      end
   endtask

   task automatic predict_row(input row_t r);
      buf_addr_t word;
      buf_wr_t   w;
      int        sel;
      int        i;
      model_bank = r.pp ? ~model_bank : 1'b0;
      out_q.delete();
      wr_q.delete();
      // output words come from buffer contents before this run's writes
      walk_generator(r.ogen);
      for (i = 0; i < walk_q.size(); i++) begin
         if (r.pp) begin
            word = {model_bank, walk_q[i][BUF_ADDR_W-2:0] >> SYM_SHIFT};
         end else begin
            word = walk_q[i] >> SYM_SHIFT;
         end
         sel = int'(walk_q[i]) % RATIO;
         out_q.push_back(pred_buf[word][sel*DATA_W +: DATA_W]);
      end
      if (r.ren) begin
         walk_generator(r.fgen);
         for (i = 0; i < walk_q.size(); i++) begin
            w.addr = r.pp ? {~model_bank, walk_q[i][BUF_ADDR_W-2:0]} : walk_q[i];
            w.data = ext_mem[(int'(r.rcfg.ext_addr >> 2) + i) % EXT_WORDS];
            wr_q.push_back(w);
            pred_buf[w.addr] = w.data;
         end
      end
      burst_addr = r.rcfg.ext_addr;
      burst_left = r.ren ? int'(r.rcfg.amount_minus_one) + 1 : 0;
      burst_max  = int'(r.rcfg.burst_len);
   endtask

   task automatic check_output();
      if (out_valid_o) begin
         assert (out_q.size() > 0) else begin
            $display("output word appeared with none expected");
            stop_on_error();
         end
         assert (out_data_o === out_q[0]) else begin
            $display("ERR %0t: out_data_o %h, expected %h", $time, out_data_o, out_q[0]);
            stop_on_error();
         end
         void'(out_q.pop_front());
         outs_seen++;
      end
   endtask

   task automatic check_write();
      if (buf_we_o) begin
         assert (wr_q.size() > 0) else begin
            $display("buffer write appeared with none expected");
            stop_on_error();
         end
         assert (buf_wr_o === wr_q[0]) else begin
            $display("ERR %0t: write %h at %h, expected %h at %h", $time, buf_wr_o.data,
                     buf_wr_o.addr, wr_q[0].data, wr_q[0].addr);
            stop_on_error();
         end
         void'(wr_q.pop_front());
         buf_mem[buf_wr_o.addr] = buf_wr_o.data;
         writes_seen++;
      end
   endtask

   task automatic check_burst();
      int exp_len;
      exp_len = (burst_left < burst_max) ? burst_left : burst_max;
      assert (db_req_o.addr == burst_addr && int'(db_req_o.len) == exp_len) else begin
         $display("ERR %0t: request %h len %0d, expected %h len %0d", $time, db_req_o.addr,
                  db_req_o.len, burst_addr, exp_len);
         stop_on_error();
      end
      burst_addr = burst_addr + 4 * exp_len;
      burst_left = burst_left - exp_len;
   endtask

   // external memory, one word per ready cycle
   task automatic serve_databus();
      logic             ready;
      logic [EXT_W-1:0] widx;
      ready      = random_bit();
      db_ready_i = ready;
      db_last_i  = 1'b0;
      if (db_valid_o) begin
         assert (cur_ren) else begin
            $display("databus request issued while the fetch is disabled");
            stop_on_error();
         end
         widx       = db_req_o.addr[EXT_W+1:2] + beat_cnt;
         db_rdata_i = ext_mem[widx];
         db_last_i  = (beat_cnt == db_req_o.len - 1'b1);
         if (ready) begin
            if (beat_cnt == '0) begin
               check_burst();
            end
            beat_cnt = db_last_i ? '0 : beat_cnt + 1'b1;
         end
      end
   endtask

   // outputs are checked before the buffer read data moves on
   always @(negedge clk) begin
      check_output();
      check_write();
      if (buf_rd_o) begin
         buf_rd_data_i = buf_mem[buf_rd_addr_o];
      end
      serve_databus();
   end

   task automatic apply_row(input int n);
      row_t r;
      r = rows[n];
      predict_row(r);
      cur_ren        = r.ren;
      writes_seen    = 0;
      outs_seen      = 0;
      read_cfg_i     = r.rcfg;
      read_gen_i     = r.fgen;
      out_gen_i      = r.ogen;
      ping_pong_i    = r.pp;
      read_enabled_i = r.ren;
      run_i          = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      assert (!done_o) else begin
         $display("done_o stayed high after the run of row %0d", n);
         stop_on_error();
      end
      @(negedge clk);
      // a run while busy must be ignored
      if (!done_o) begin
         run_i          = 1'b1;
         ping_pong_i    = ~r.pp;
         read_enabled_i = 1'b1;
         read_cfg_i     = '1;
         read_gen_i     = '1;
         out_gen_i      = '1;
         @(negedge clk);
         run_i = 1'b0;
      end
      while (!done_o) begin
         @(negedge clk);
      end
      assert (wr_q.size() == 0 && out_q.size() == 0 && burst_left == 0) else begin
         $display("row %0d finished with writes, outputs or burst words outstanding", n);
         stop_on_error();
      end
      assert (writes_seen == int'(r.exp_words) && outs_seen == int'(r.exp_outs)) else begin
         $display("ERR %0t: row %0d gave %0d writes and %0d outputs, expected %0d and %0d",
                  $time, n, writes_seen, outs_seen, r.exp_words, r.exp_outs);
         stop_on_error();
      end
      @(negedge clk);
   endtask

   initial begin
      int limit;
      lfsr           = SEED;
      rst            = 1'b1;
      run_i          = 1'b0;
      ping_pong_i    = 1'b0;
      read_enabled_i = 1'b0;
      read_cfg_i     = '0;
      read_gen_i     = '0;
      out_gen_i      = '0;
      db_ready_i     = 1'b0;
      db_rdata_i     = '0;
      db_last_i      = 1'b0;
      buf_rd_data_i  = '0;
      model_bank     = 1'b0;
      cur_ren        = 1'b0;
      burst_addr     = '0;
      burst_left     = 0;
      burst_max      = 1;
      beat_cnt       = '0;
      writes_seen    = 0;
      outs_seen      = 0;
      for (int w = 0; w < EXT_WORDS; w++) begin
         for (int b = 0; b < AXI_DATA_W; b++) begin
            ext_mem[w][b] = random_bit();
         end
      end
      for (int a = 0; a < BUF_WORDS; a++) begin
         buf_mem[a]  = buf_fill(buf_addr_t'(a));
         pred_buf[a] = buf_fill(buf_addr_t'(a));
      end
      load_table();
      limit = RESET_CYCLES;
      for (int n = 0; n < NUM_ROWS; n++) begin
         limit += 4 * (rows[n].exp_words + rows[n].ogen.iter * rows[n].ogen.per) + 100;
      end
      fork
         begin
            #(limit * CLK_PERIOD);
            $display("watchdog expired after %0d cycles with a run still busy", limit);
            stop_on_error();
         end
      join_none
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      assert (done_o && !db_valid_o && !buf_we_o && !buf_rd_o && !out_valid_o) else begin
         $display("outputs not idle after reset");
         stop_on_error();
      end
      for (int n = 0; n < NUM_ROWS; n++) begin
         apply_row(n);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

// File: compile.f
vread_pkg.sv
vread_cfg_decode.sv
vread_addr_gen.sv
vread_burst_fetch.sv
vread_join.sv
vread_output_stream.sv
vread_top.sv
vread_chk.sv
tb_vread.sv
